//--- logic/dataPathPkg.sv
/* Widths, register indices, ALU codes and the IR word layout for the datapath.
   Index 7 is never a register; reads of it give zero and writes to it are dropped. */

package dataPathPkg;

	//------------------------------
	// Datapath sizes
	//------------------------------
	localparam int dataWidth     = 32;
	localparam int regCount      = 7;
	localparam int regIndexWidth = 3;
	localparam int irFieldWidth  = 5;
	localparam int aluOpWidth    = 4;

	//------------------------------
	// Register indices
	//------------------------------
	// General registers
	localparam logic [regIndexWidth-1:0] REG_R0 = 3'd0;
	localparam logic [regIndexWidth-1:0] REG_R1 = 3'd1;
	localparam logic [regIndexWidth-1:0] REG_R2 = 3'd2;
	localparam logic [regIndexWidth-1:0] REG_R3 = 3'd3;
	// Special registers
	localparam logic [regIndexWidth-1:0] REG_RS = 3'd4;
	localparam logic [regIndexWidth-1:0] REG_PC = 3'd5;
	localparam logic [regIndexWidth-1:0] REG_IR = 3'd6;
	// No register selected
	localparam logic [regIndexWidth-1:0] regNone = 3'd7;

	//------------------------------
	// ALU operation codes
	//------------------------------
	// Codes 8 to 15 are unassigned, result and flags all zero
	localparam logic [aluOpWidth-1:0] ALU_ADD   = 4'd0;
	localparam logic [aluOpWidth-1:0] ALU_SUB   = 4'd1;
	localparam logic [aluOpWidth-1:0] ALU_AND   = 4'd2;
	localparam logic [aluOpWidth-1:0] ALU_OR    = 4'd3;
	localparam logic [aluOpWidth-1:0] ALU_XOR   = 4'd4;
	localparam logic [aluOpWidth-1:0] ALU_NOTA  = 4'd5;
	localparam logic [aluOpWidth-1:0] ALU_INCA  = 4'd6;
	localparam logic [aluOpWidth-1:0] ALU_PASSA = 4'd7;

	//------------------------------
	// Instruction word
	//------------------------------
	// Same 32 bits seen as a raw word or as SPARC-like format 3 fields
	typedef union packed {
		logic [dataWidth-1:0] raw;
		struct packed {
			logic [1:0]              op;      // 31:30
			logic [irFieldWidth-1:0] rd;      // 29:25, destination
			logic [5:0]              op3;     // 24:19
			logic [irFieldWidth-1:0] rs1;     // 18:14, first source
			logic                    i;       // 13
			logic [7:0]              unused;  // 12:5
			logic [irFieldWidth-1:0] rs2;     // 4:0, second source
		} f;
	} instrWord;

endpackage

//--- logic/operandDecode.sv
/* Port index selection and one-hot decode, purely combinational.
   IR fields at 7 or above select no register; all-zero enables mean no access. */
`timescale 1ns/1ps

module operandDecode (
	input  dataPathPkg::instrWord                 irWord,
	input  logic [dataPathPkg::regIndexWidth-1:0] regSelA,
	input  logic [dataPathPkg::regIndexWidth-1:0] regSelB,
	input  logic [dataPathPkg::regIndexWidth-1:0] regSelC,
	input  logic                                  fromIrA,
	input  logic                                  fromIrB,
	input  logic                                  fromIrC,
	input  logic [dataPathPkg::regIndexWidth-1:0] clearSel,
	output logic [dataPathPkg::regCount-1:0]      readEnA,
	output logic [dataPathPkg::regCount-1:0]      readEnB,
	output logic [dataPathPkg::regCount-1:0]      loadEn,
	output logic [dataPathPkg::regCount-1:0]      clearEn
);

	import dataPathPkg::*;

	// Final index per port
	logic [regIndexWidth-1:0] indexA;
	logic [regIndexWidth-1:0] indexB;
	logic [regIndexWidth-1:0] indexC;

	//------------------------------
	// Helpers
	//------------------------------
	// IR field or control index, out-of-range IR field to regNone
	function automatic logic [regIndexWidth-1:0] pickIndex(
		input logic                     fromIr,
		input logic [irFieldWidth-1:0]  irField,
		input logic [regIndexWidth-1:0] ctrlIndex
	);
		logic [regIndexWidth-1:0] index;
		if (fromIr) begin
			if (irField >= irFieldWidth'(regCount)) begin
				index = regNone;
			end else begin
				index = irField[regIndexWidth-1:0];
			end
		end else begin
			index = ctrlIndex;
		end
		return index;
	endfunction

	// One bit per register, nothing for regNone
	function automatic logic [regCount-1:0] oneHot(input logic [regIndexWidth-1:0] index);
		logic [regCount-1:0] enables;
		enables = '0;
		if (index < regIndexWidth'(regCount)) begin
			enables[index] = 1'b1;
		end
		return enables;
	endfunction

	//------------------------------
	// Index selection
	//------------------------------
	// A from rs1, B from rs2, C from rd
	always_comb begin
		indexA = pickIndex(fromIrA, irWord.f.rs1, regSelA);
		indexB = pickIndex(fromIrB, irWord.f.rs2, regSelB);
		indexC = pickIndex(fromIrC, irWord.f.rd, regSelC);
	end

	// Decoders
	always_comb begin
		readEnA = oneHot(indexA);
		readEnB = oneHot(indexB);
		loadEn  = oneHot(indexC);
		// Clear index always comes from control
		clearEn = oneHot(clearSel);
	end

endmodule

//--- logic/regBank.sv
/* Seven 32-bit registers r0-r3, RS, PC, IR with synchronous active-high reset.
   Clear beats load on the same register; enables are expected one-hot or zero. */
`timescale 1ns/1ps

module regBank (
	input  logic                              CLOCK_50,
	input  logic                              reset,
	input  logic [dataPathPkg::regCount-1:0]  readEnA,
	input  logic [dataPathPkg::regCount-1:0]  readEnB,
	input  logic [dataPathPkg::regCount-1:0]  loadEn,
	input  logic [dataPathPkg::regCount-1:0]  clearEn,
	input  logic [dataPathPkg::dataWidth-1:0] writeData,
	output logic [dataPathPkg::dataWidth-1:0] operandA,
	output logic [dataPathPkg::dataWidth-1:0] operandB,
	output dataPathPkg::instrWord             irWord
);

	import dataPathPkg::*;

	// Register storage, indexed by REG_* codes
	logic [dataWidth-1:0] regFile [regCount];

	//------------------------------
	// Write side
	//------------------------------
	// Reset, then clear, then write-back
	always_ff @(posedge CLOCK_50) begin
		for (int k = 0; k < regCount; k++) begin
			if (reset) begin
				regFile[k] <= '0;
			end else if (clearEn[k]) begin
				regFile[k] <= '0;
			end else if (loadEn[k]) begin
				regFile[k] <= writeData;
			end
		end
	end

	//------------------------------
	// Read side
	//------------------------------
	// AND-OR mux per port
	// Zero enable gives zero operand
	always_comb begin
		operandA = '0;
		operandB = '0;
		for (int k = 0; k < regCount; k++) begin
			operandA = operandA | (regFile[k] & {dataWidth{readEnA[k]}});
			operandB = operandB | (regFile[k] & {dataWidth{readEnB[k]}});
		end
	end

	// IR straight to the operand decoder
	assign irWord.raw = regFile[REG_IR];

endmodule

//--- logic/aluExecute.sv
/* Combinational ALU, eight operations with active-high flags.
   Carry on SUB is the unsigned borrow; unassigned codes give zero result and flags. */
`timescale 1ns/1ps

module aluExecute (
	input  logic [dataPathPkg::dataWidth-1:0]  operandA,
	input  logic [dataPathPkg::dataWidth-1:0]  operandB,
	input  logic [dataPathPkg::aluOpWidth-1:0] aluOp,
	output logic [dataPathPkg::dataWidth-1:0]  result,
	output logic                               zero,
	output logic                               negative,
	output logic                               carry,
	output logic                               overflow
);

	import dataPathPkg::*;

	// Extended sums, MSB is carry out
	logic [dataWidth:0] sumAB;
	logic [dataWidth:0] diffAB;
	logic [dataWidth:0] incA;
	// High for codes 0 to 7
	logic               opValid;

	//------------------------------
	// Arithmetic
	//------------------------------
	always_comb begin
		sumAB  = {1'b0, operandA} + {1'b0, operandB};
		diffAB = {1'b0, operandA} - {1'b0, operandB};
		incA   = {1'b0, operandA} + 1'b1;
	end

	//------------------------------
	// Operation select
	//------------------------------
	always_comb begin
		result   = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		opValid  = 1'b1;
		case (aluOp)
			ALU_ADD: begin
				result   = sumAB[dataWidth-1:0];
				carry    = sumAB[dataWidth];
				// Same-sign operands, sign flipped
				overflow = (operandA[dataWidth-1] == operandB[dataWidth-1]) &&
					(sumAB[dataWidth-1] != operandA[dataWidth-1]);
			end
			ALU_SUB: begin
				result   = diffAB[dataWidth-1:0];
				// Borrow, A below B unsigned
				carry    = diffAB[dataWidth];
				overflow = (operandA[dataWidth-1] != operandB[dataWidth-1]) &&
					(diffAB[dataWidth-1] != operandA[dataWidth-1]);
			end
			ALU_AND:   result = operandA & operandB;
			ALU_OR:    result = operandA | operandB;
			ALU_XOR:   result = operandA ^ operandB;
			ALU_NOTA:  result = ~operandA;
			ALU_INCA: begin
				result   = incA[dataWidth-1:0];
				carry    = incA[dataWidth];
				// Only 0x7FFFFFFF rolls into negative
				overflow = !operandA[dataWidth-1] && incA[dataWidth-1];
			end
			ALU_PASSA: result = operandA;
			default:   opValid = 1'b0;
		endcase
	end

	// Result flags, all low on unassigned codes
	assign zero     = opValid && (result == '0);
	assign negative = result[dataWidth-1];

endmodule

//--- logic/dataPath.sv
/* Top of the register datapath, no external data input.
   Decode, read and ALU settle in the same cycle; write-back on rising CLOCK_50. */
`timescale 1ns/1ps

module dataPath (
	input  logic                               CLOCK_50,
	input  logic                               reset,
	input  logic [dataPathPkg::regIndexWidth-1:0] regSelA,
	input  logic [dataPathPkg::regIndexWidth-1:0] regSelB,
	input  logic [dataPathPkg::regIndexWidth-1:0] regSelC,
	input  logic [dataPathPkg::regIndexWidth-1:0] clearSel,
	input  logic                               fromIrA,
	input  logic                               fromIrB,
	input  logic                               fromIrC,
	input  logic [dataPathPkg::aluOpWidth-1:0] aluOp,
	output logic [dataPathPkg::dataWidth-1:0]  result,
	output logic                               zero,
	output logic                               negative,
	output logic                               carry,
	output logic                               overflow
);

	import dataPathPkg::*;

	// Decode to bank
	logic [regCount-1:0]  readEnA;
	logic [regCount-1:0]  readEnB;
	logic [regCount-1:0]  loadEn;
	logic [regCount-1:0]  clearEn;
	// Bank to ALU and back to decode
	logic [dataWidth-1:0] operandA;
	logic [dataWidth-1:0] operandB;
	instrWord             irWord;

	//------------------------------
	// Index selection and decode
	//------------------------------
	operandDecode decode (
		.irWord  (irWord),
		.regSelA (regSelA),
		.regSelB (regSelB),
		.regSelC (regSelC),
		.fromIrA (fromIrA),
		.fromIrB (fromIrB),
		.fromIrC (fromIrC),
		.clearSel(clearSel),
		.readEnA (readEnA),
		.readEnB (readEnB),
		.loadEn  (loadEn),
		.clearEn (clearEn)
	);

	//------------------------------
	// Register bank
	//------------------------------
	// ALU result is the write-back data
	regBank bank (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.readEnA  (readEnA),
		.readEnB  (readEnB),
		.loadEn   (loadEn),
		.clearEn  (clearEn),
		.writeData(result),
		.operandA (operandA),
		.operandB (operandB),
		.irWord   (irWord)
	);

	//------------------------------
	// ALU
	//------------------------------
	aluExecute execute (
		.operandA(operandA),
		.operandB(operandB),
		.aluOp   (aluOp),
		.result  (result),
		.zero    (zero),
		.negative(negative),
		.carry   (carry),
		.overflow(overflow)
	);

endmodule

//--- test/regBank_sva.sv
/* Bound into regBank, checks clear, write-back and hold of every register.
   Checks are off while reset is high. */
`timescale 1ns/1ps

module regBank_sva (
	input logic                              CLOCK_50,
	input logic                              reset,
	input logic [dataPathPkg::regCount-1:0]  loadEn,
	input logic [dataPathPkg::regCount-1:0]  clearEn,
	input logic [dataPathPkg::dataWidth-1:0] writeData,
	input logic [dataPathPkg::dataWidth-1:0] regFile [dataPathPkg::regCount]
);

	import dataPathPkg::*;

	// Decoder gives one register at most
	oneLoad: assert property (@(posedge CLOCK_50) disable iff (reset) $onehot0(loadEn))
		else $error("loadEn has more than one bit set");
	oneClear: assert property (@(posedge CLOCK_50) disable iff (reset) $onehot0(clearEn))
		else $error("clearEn has more than one bit set");

	//------------------------------
	// Per register
	//------------------------------
	for (genvar k = 0; k < regCount; k++) begin : perReg
		// Clear wins over load
		clearToZero: assert property (@(posedge CLOCK_50) disable iff (reset)
			clearEn[k] |=> regFile[k] == '0)
			else $error("register %0d not zero after clear", k);
		loadTakesData: assert property (@(posedge CLOCK_50) disable iff (reset)
			loadEn[k] && !clearEn[k] |=> regFile[k] == $past(writeData))
			else $error("register %0d did not take the write data", k);
		// No enable, no change
		holdValue: assert property (@(posedge CLOCK_50) disable iff (reset)
			!loadEn[k] && !clearEn[k] |=> regFile[k] == $past(regFile[k]))
			else $error("register %0d changed without an enable", k);
	end

endmodule

//--- test/tb_dataPath.sv
/* Self-checking testbench for dataPath, a stimulus table replayed against a register model.
   Inputs change on the rising edge, outputs are sampled on the falling edge. */
`timescale 1ns/1ps

module tb_dataPath;

	import dataPathPkg::*;

	localparam int resetCycles = 5;
	localparam int cycleLimit  = 2000;
	localparam int randomRows  = 60;

	// DUT ports
	logic                     CLOCK_50;
	logic                     reset;
	logic [regIndexWidth-1:0] regSelA;
	logic [regIndexWidth-1:0] regSelB;
	logic [regIndexWidth-1:0] regSelC;
	logic [regIndexWidth-1:0] clearSel;
	logic                     fromIrA;
	logic                     fromIrB;
	logic                     fromIrC;
	logic [aluOpWidth-1:0]    aluOp;
	logic [dataWidth-1:0]     result;
	logic                     zero;
	logic                     negative;
	logic                     carry;
	logic                     overflow;

	// Register model, same indices as the bank
	logic [dataWidth-1:0] model [regCount];

	//------------------------------
	// Stimulus table
	//------------------------------
	// One entry per cycle, IR select bits ordered A B C
	string                    rowName [$];
	logic [aluOpWidth-1:0]    rowOp [$];
	logic [regIndexWidth-1:0] rowA [$];
	logic [regIndexWidth-1:0] rowB [$];
	logic [regIndexWidth-1:0] rowC [$];
	logic [regIndexWidth-1:0] rowClr [$];
	logic [2:0]               rowIr [$];

	integer seed;
	int     cycleCount;
	int     errorCount;

	dataPath dut_i (
		.CLOCK_50(CLOCK_50),
		.reset   (reset),
		.regSelA (regSelA),
		.regSelB (regSelB),
		.regSelC (regSelC),
		.clearSel(clearSel),
		.fromIrA (fromIrA),
		.fromIrB (fromIrB),
		.fromIrC (fromIrC),
		.aluOp   (aluOp),
		.result  (result),
		.zero    (zero),
		.negative(negative),
		.carry   (carry),
		.overflow(overflow)
	);

	bind regBank regBank_sva bankChecks (
		.CLOCK_50 (CLOCK_50),
		.reset    (reset),
		.loadEn   (loadEn),
		.clearEn  (clearEn),
		.writeData(writeData),
		.regFile  (regFile)
	);

	always #5 CLOCK_50 = ~CLOCK_50;

	task automatic stopOnError();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string testName, input string what,
		input logic [dataWidth-1:0] expected, input logic [dataWidth-1:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s %s expected %h actual %h", testName, what, expected, actual);
			stopOnError();
		end
	endtask

	// One clock edge, cycle budget checked on every wait
	task automatic clockEdge(input logic rising);
		if (rising) begin
			@(posedge CLOCK_50);
			cycleCount++;
		end else begin
			@(negedge CLOCK_50);
		end
		if (cycleCount > cycleLimit) begin
			errorCount++;
			$display("Timeout after %0d cycles before the table was done", cycleLimit);
			stopOnError();
		end
	endtask

	//------------------------------
	// Reference model
	//------------------------------
	// IR field 7 and up means no register
	function automatic logic [regIndexWidth-1:0] modelIndex(input logic fromIr,
		input logic [irFieldWidth-1:0] field, input logic [regIndexWidth-1:0] ctrl);
		if (!fromIr) begin
			return ctrl;
		end
		if (field > 5'd6) begin
			return regNone;
		end
		return field[regIndexWidth-1:0];
	endfunction

	function automatic logic [dataWidth-1:0] modelRead(input logic [regIndexWidth-1:0] index);
		if (index == regNone) begin
			return '0;
		end
		return model[index];
	endfunction

	// Flags packed as zero, negative, carry, overflow
	task automatic predict(input logic [aluOpWidth-1:0] op, input logic [dataWidth-1:0] a,
		input logic [dataWidth-1:0] b, output logic [dataWidth-1:0] r, output logic [3:0] flags);
		longint exact;
		logic   valid;
		logic   c;
		logic   v;
		valid = 1'b1;
		c     = 1'b0;
		v     = 1'b0;
		r     = '0;
		exact = 0;
		case (op)
			ALU_ADD: begin
				r     = a + b;
				c     = (64'(a) + 64'(b)) > 64'hFFFF_FFFF;
				exact = longint'($signed(a)) + longint'($signed(b));
				v     = exact != longint'($signed(r));
			end
			ALU_SUB: begin
				r     = a - b;
				c     = a < b;
				exact = longint'($signed(a)) - longint'($signed(b));
				v     = exact != longint'($signed(r));
			end
			ALU_INCA: begin
				r     = a + 32'd1;
				c     = a == 32'hFFFF_FFFF;
				exact = longint'($signed(a)) + 1;
				v     = exact != longint'($signed(r));
			end
			ALU_AND:   r = a & b;
			ALU_OR:    r = a | b;
			ALU_XOR:   r = a ^ b;
			ALU_NOTA:  r = ~a;
			ALU_PASSA: r = a;
			default:   valid = 1'b0;
		endcase
		flags = {valid && (r == '0), r[dataWidth-1], c, v};
	endtask

	// Check one row, then advance the model past the coming edge
	task automatic checkAndUpdate(input int i);
		logic [regIndexWidth-1:0] indexA;
		logic [regIndexWidth-1:0] indexB;
		logic [regIndexWidth-1:0] indexC;
		logic [dataWidth-1:0]     ir;
		logic [dataWidth-1:0]     expResult;
		logic [3:0]               expFlags;
		ir     = model[REG_IR];
		indexA = modelIndex(rowIr[i][2], ir[18:14], rowA[i]);
		indexB = modelIndex(rowIr[i][1], ir[4:0], rowB[i]);
		indexC = modelIndex(rowIr[i][0], ir[29:25], rowC[i]);
		predict(rowOp[i], modelRead(indexA), modelRead(indexB), expResult, expFlags);
		checkValue(rowName[i], "result", expResult, result);
		checkValue(rowName[i], "zero", dataWidth'(expFlags[3]), dataWidth'(zero));
		checkValue(rowName[i], "negative", dataWidth'(expFlags[2]), dataWidth'(negative));
		checkValue(rowName[i], "carry", dataWidth'(expFlags[1]), dataWidth'(carry));
		checkValue(rowName[i], "overflow", dataWidth'(expFlags[0]), dataWidth'(overflow));
		// Clear first, load skipped on the cleared register
		if (rowClr[i] != regNone) begin
			model[rowClr[i]] = '0;
		end
		if (indexC != regNone && indexC != rowClr[i]) begin
			model[indexC] = expResult;
		end
	endtask

	task automatic addRow(input string name, input logic [aluOpWidth-1:0] op,
		input logic [regIndexWidth-1:0] a, input logic [regIndexWidth-1:0] b,
		input logic [regIndexWidth-1:0] c, input logic [regIndexWidth-1:0] clr,
		input logic [2:0] ir);
		rowName.push_back(name);
		rowOp.push_back(op);
		rowA.push_back(a);
		rowB.push_back(b);
		rowC.push_back(c);
		rowClr.push_back(clr);
		rowIr.push_back(ir);
	endtask

	//------------------------------
	// Table contents
	//------------------------------
	task automatic buildTable();
		logic [31:0] rnd;
		logic [31:0] pick;
		// Everything zero after reset
		for (int k = 0; k < regCount; k++) begin
			addRow($sformatf("reset read %0d", k), ALU_PASSA, 3'(k), regNone, regNone,
				regNone, 3'b000);
		end
		// Seed values from the zero operand
		addRow("nota none to r0", ALU_NOTA, regNone, regNone, REG_R0, regNone, 3'b000);
		addRow("inca none to r1", ALU_INCA, regNone, regNone, REG_R1, regNone, 3'b000);
		addRow("inca all ones carry", ALU_INCA, REG_R0, regNone, regNone, regNone, 3'b000);
		addRow("add all ones carry", ALU_ADD, REG_R0, REG_R1, regNone, regNone, 3'b000);
		addRow("sub zero minus one", ALU_SUB, regNone, REG_R1, regNone, regNone, 3'b000);
		addRow("add r1 r1 to r2", ALU_ADD, REG_R1, REG_R1, REG_R2, regNone, 3'b000);
		addRow("add r2 r1 to r3", ALU_ADD, REG_R2, REG_R1, REG_R3, regNone, 3'b000);
		addRow("sub r3 r1 to rs", ALU_SUB, REG_R3, REG_R1, REG_RS, regNone, 3'b000);
		addRow("xor r0 r3 to pc", ALU_XOR, REG_R0, REG_R3, REG_PC, regNone, 3'b000);
		addRow("or pc r1 to r0", ALU_OR, REG_PC, REG_R1, REG_R0, regNone, 3'b000);
		addRow("and pc r3 to rs", ALU_AND, REG_PC, REG_R3, REG_RS, regNone, 3'b000);
		for (int k = 0; k < regCount; k++) begin
			addRow($sformatf("built read %0d", k), ALU_PASSA, 3'(k), regNone, regNone,
				regNone, 3'b000);
		end
		// IR word rd 2, rs1 3, rs2 1 built bit by bit from doubling r2
		addRow("or ir bit 0", ALU_OR, REG_IR, REG_R1, REG_IR, regNone, 3'b000);
		for (int bitPos = 2; bitPos < dataWidth; bitPos++) begin
			addRow($sformatf("double r2 to bit %0d", bitPos), ALU_ADD, REG_R2, REG_R2, REG_R2,
				regNone, 3'b000);
			if (bitPos == 14 || bitPos == 15 || bitPos == 26) begin
				addRow($sformatf("or ir bit %0d", bitPos), ALU_OR, REG_IR, REG_R2, REG_IR,
					regNone, 3'b000);
			end
		end
		addRow("nota r2 to r3", ALU_NOTA, REG_R2, regNone, REG_R3, regNone, 3'b000);
		addRow("inca max positive", ALU_INCA, REG_R3, regNone, regNone, regNone, 3'b000);
		// Control fields point at r0 and must be ignored
		addRow("ir read rs1", ALU_PASSA, REG_R0, REG_R0, regNone, regNone, 3'b100);
		// Difference is new to r2, so the rd write shows on the next read
		addRow("ir sub rs1 rs2 to rd", ALU_SUB, REG_R0, REG_R0, REG_R0, regNone, 3'b111);
		addRow("read r2 after ir write", ALU_PASSA, REG_R2, regNone, regNone, regNone, 3'b000);
		addRow("read r0 after ir write", ALU_PASSA, REG_R0, regNone, regNone, regNone, 3'b000);
		// Clear, alone and against a load
		addRow("clear r1", ALU_PASSA, REG_R1, regNone, regNone, REG_R1, 3'b000);
		addRow("read r1 after clear", ALU_PASSA, REG_R1, regNone, regNone, regNone, 3'b000);
		addRow("clear beats load r0", ALU_INCA, regNone, regNone, REG_R0, REG_R0, 3'b000);
		addRow("read r0 after clear", ALU_PASSA, REG_R0, regNone, regNone, regNone, 3'b000);
		// No register as source or destination
		addRow("write to none", ALU_NOTA, regNone, regNone, regNone, regNone, 3'b000);
		addRow("read none", ALU_PASSA, regNone, regNone, regNone, regNone, 3'b000);
		addRow("add r3 none", ALU_ADD, REG_R3, regNone, regNone, regNone, 3'b000);
		for (int k = 0; k < regCount; k++) begin
			addRow($sformatf("final read %0d", k), ALU_PASSA, 3'(k), regNone, regNone,
				regNone, 3'b000);
		end
		// Random rows, unassigned codes included
		for (int n = 0; n < randomRows; n++) begin
			rnd  = $random(seed);
			pick = $random(seed);
			addRow($sformatf("random %0d", n), rnd[3:0], rnd[6:4], rnd[9:7], rnd[12:10],
				(pick[2:0] == 3'd0) ? rnd[15:13] : regNone,
				{pick[5:4] == 2'd0, pick[7:6] == 2'd0, pick[9:8] == 2'd0});
		end
	endtask

	//------------------------------
	// Main sequence
	//------------------------------
	initial begin
		CLOCK_50   = 1'b0;
		reset      = 1'b1;
		regSelA    = regNone;
		regSelB    = regNone;
		regSelC    = regNone;
		clearSel   = regNone;
		fromIrA    = 1'b0;
		fromIrB    = 1'b0;
		fromIrC    = 1'b0;
		aluOp      = ALU_PASSA;
		seed       = 32'hbfe14972;
		cycleCount = 0;
		errorCount = 0;
		for (int k = 0; k < regCount; k++) begin
			model[k] = '0;
		end
		buildTable();
		for (int n = 0; n < resetCycles; n++) begin
			clockEdge(1'b1);
		end
		reset <= 1'b0;
		for (int i = 0; i < rowName.size(); i++) begin
			clockEdge(1'b1);
			regSelA  <= rowA[i];
			regSelB  <= rowB[i];
			regSelC  <= rowC[i];
			clearSel <= rowClr[i];
			fromIrA  <= rowIr[i][2];
			fromIrB  <= rowIr[i][1];
			fromIrC  <= rowIr[i][0];
			aluOp    <= rowOp[i];
			clockEdge(1'b0);
			checkAndUpdate(i);
		end
		if (errorCount == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stopOnError();
		end
	end

endmodule

//--- flist.f
logic/dataPathPkg.sv
logic/operandDecode.sv
logic/regBank.sv
logic/aluExecute.sv
logic/dataPath.sv
test/regBank_sva.sv
test/tb_dataPath.sv

//--- Makefile
# Verilator build and run of the datapath testbench

TOP     = tb_dataPath
SOURCES = $(shell cat flist.f)
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): flist.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f

# Pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
